//--- rtl/ofm_pkg.sv
// checksum offload transmit path
// shared widths, FIFO records, FSM states and sizes
package ofm_pkg;

   // queue and buffer sizes
   localparam int FIFO_DEPTH       = 16;
   // leaves room for the beats still in flight behind the registered flag
   localparam int FIFO_AFULL_LEVEL = 12;
   localparam int FIFO_AW          = $clog2(FIFO_DEPTH);
   localparam int FRAME_WORDS      = 32;
   localparam int FRAME_AW         = $clog2(FRAME_WORDS);
   localparam int LANES            = 8;
   // 256 bytes of pairs plus the seed fit easily
   localparam int ACC_W            = 24;

   // control word encodings
   localparam logic [3:0] TX_FLAG_OFFLOAD = 4'b1000;
   localparam logic [1:0] TX_CTRL_INSERT  = 2'b01;

   typedef logic [63:0]      data_word_t;
   typedef logic [7:0]       keep_t;
   typedef logic [31:0]      ctrl_word_t;
   typedef logic [15:0]      csum_t;
   typedef logic [ACC_W-1:0] acc_t;

   // one data FIFO entry
   typedef struct packed {
      logic       last;
      keep_t      keep;
      data_word_t data;
   } data_beat_t;

   // one control FIFO entry
   typedef struct packed {
      logic  enable;
      csum_t begin_ofs;
      csum_t insert_ofs;
      csum_t init;
   } csum_ctrl_t;

   typedef enum logic [1:0] {
      IN_IDLE,
      IN_CTRL,
      IN_WAIT,
      IN_DATA
   } in_state_t;

   typedef enum logic [1:0] {
      ENG_IDLE,
      ENG_SUM,
      ENG_DONE
   } eng_state_t;

endpackage

//--- rtl/ofm_sync_fifo.sv
`timescale 1ns/1ps
// synchronous FIFO with almost-full flag
// head entry shows on rdata while not_empty is high
module ofm_sync_fifo
#(
   parameter int WIDTH = 73
)
(
   input  logic             mm2s_clk,
   input  logic             mm2s_resetn,
   input  logic             wren,
   input  logic [WIDTH-1:0] wdata,
   input  logic             rden,
   output logic [WIDTH-1:0] rdata,
   output logic             not_empty,
   output logic             almost_full
);

   logic [WIDTH-1:0]            mem [ofm_pkg::FIFO_DEPTH];
   logic [ofm_pkg::FIFO_AW-1:0] wr_ptr;
   logic [ofm_pkg::FIFO_AW-1:0] rd_ptr;
   logic [ofm_pkg::FIFO_AW:0]   count;

   always_ff @(posedge mm2s_clk)
   begin
      if (wren)
         mem[wr_ptr] <= wdata;
   end

   // pointers wrap at the power-of-two depth
   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wren)
            wr_ptr <= wr_ptr + 1'b1;
         if (rden)
            rd_ptr <= rd_ptr + 1'b1;
         if (wren && !rden)
            count <= count + 1'b1;
         else if (rden && !wren)
            count <= count - 1'b1;
      end
   end

   assign rdata       = mem[rd_ptr];
   assign not_empty   = (count != '0);
   assign almost_full = (count >= (ofm_pkg::FIFO_AW + 1)'(ofm_pkg::FIFO_AFULL_LEVEL));

   // the writer's afull margin must cover its in-flight beats
   a_no_overflow: assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
      wren |-> (count != (ofm_pkg::FIFO_AW + 1)'(ofm_pkg::FIFO_DEPTH)));
   // reader pops only what is offered
   a_no_underflow: assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
      rden |-> not_empty);

endmodule

//--- rtl/ofm_in_fsm.sv
`timescale 1ns/1ps
// transmit input side
// parses the txc control words into a checksum record and
// forwards the txd beats, one FIFO write per record or beat
module ofm_in_fsm
(
   input  logic                mm2s_clk,
   input  logic                mm2s_resetn,
   input  ofm_pkg::data_word_t txd_tdata,
   input  ofm_pkg::keep_t      txd_tkeep,
   input  logic                txd_tvalid,
   input  logic                txd_tlast,
   output logic                txd_tready,
   input  ofm_pkg::ctrl_word_t txc_tdata,
   input  logic [3:0]          txc_tkeep,
   input  logic                txc_tvalid,
   input  logic                txc_tlast,
   output logic                txc_tready,
   input  logic                ctrl_fifo_afull,
   output ofm_pkg::csum_ctrl_t ctrl_fifo_wdata,
   output logic                ctrl_fifo_wren,
   input  logic                data_fifo_afull,
   output ofm_pkg::data_beat_t data_fifo_wdata,
   output logic                data_fifo_wren
);

   ofm_pkg::in_state_t state;
   ofm_pkg::in_state_t state_nxt;
   logic               ctrl_afull_q;
   logic               data_afull_q;
   logic [2:0]         word_cnt;
   logic               txc_hs;
   logic               txd_hs;
   logic [3:0]         flag_q;
   logic [3:0]         flag_nxt;
   logic [1:0]         cntrl_q;
   logic [1:0]         cntrl_nxt;
   ofm_pkg::csum_t     begin_q;
   ofm_pkg::csum_t     begin_nxt;
   ofm_pkg::csum_t     insert_q;
   ofm_pkg::csum_t     insert_nxt;
   ofm_pkg::csum_t     init_q;
   ofm_pkg::csum_t     init_nxt;

   assign txc_hs = txc_tvalid && txc_tready;
   assign txd_hs = txd_tvalid && txd_tready;

   // control words first, then the data beats of the same frame
   always_comb
   begin
      state_nxt = state;
      case (state)
         ofm_pkg::IN_IDLE:
            // new frame only with room in both queues
            if (txc_tvalid && !ctrl_afull_q && !data_afull_q)
               state_nxt = ofm_pkg::IN_CTRL;
         ofm_pkg::IN_CTRL:
            if (txc_hs && txc_tlast)
               state_nxt = ofm_pkg::IN_WAIT;
         ofm_pkg::IN_WAIT:
            if (txd_tvalid && !data_afull_q)
               state_nxt = ofm_pkg::IN_DATA;
         ofm_pkg::IN_DATA:
            if (txd_hs && txd_tlast)
               state_nxt = ofm_pkg::IN_IDLE;
         default:
            state_nxt = ofm_pkg::IN_IDLE;
      endcase
   end

   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         state          <= ofm_pkg::IN_IDLE;
         word_cnt       <= '0;
         ctrl_afull_q   <= 1'b0;
         data_afull_q   <= 1'b0;
         txc_tready     <= 1'b0;
         txd_tready     <= 1'b0;
         ctrl_fifo_wren <= 1'b0;
         data_fifo_wren <= 1'b0;
      end
      else
      begin
         state        <= state_nxt;
         ctrl_afull_q <= ctrl_fifo_afull;
         data_afull_q <= data_fifo_afull;
         if (state == ofm_pkg::IN_IDLE)
            word_cnt <= '0;
         else if (txc_hs)
            word_cnt <= word_cnt + 3'd1;
         // ready lags the state by one cycle, drops right after last
         txc_tready <= (state == ofm_pkg::IN_CTRL) && !(txc_hs && txc_tlast);
         // mid-frame pause when the data queue runs full
         txd_tready <= (state == ofm_pkg::IN_DATA) && !(txd_hs && txd_tlast) &&
                       !data_afull_q;
         ctrl_fifo_wren <= txc_hs && txc_tlast;
         data_fifo_wren <= txd_hs;
      end
   end

   // field pick by word index, only bytes with keep set
   always_comb
   begin
      flag_nxt   = flag_q;
      cntrl_nxt  = cntrl_q;
      begin_nxt  = begin_q;
      insert_nxt = insert_q;
      init_nxt   = init_q;
      if (txc_hs)
      begin
         case (word_cnt)
            3'd0:
               if (txc_tkeep[3])
                  flag_nxt = txc_tdata[31:28];
            3'd1:
               if (txc_tkeep[0])
                  cntrl_nxt = txc_tdata[1:0];
            3'd2:
            begin
               if (&txc_tkeep[3:2])
                  begin_nxt = txc_tdata[31:16];
               if (&txc_tkeep[1:0])
                  insert_nxt = txc_tdata[15:0];
            end
            3'd3:
               if (&txc_tkeep[1:0])
                  init_nxt = txc_tdata[15:0];
            default:
               ;
         endcase
      end
   end

   // record built from the merged fields, so the last word counts too
   always_ff @(posedge mm2s_clk)
   begin
      flag_q                     <= flag_nxt;
      cntrl_q                    <= cntrl_nxt;
      begin_q                    <= begin_nxt;
      insert_q                   <= insert_nxt;
      init_q                     <= init_nxt;
      ctrl_fifo_wdata.enable     <= (flag_nxt == ofm_pkg::TX_FLAG_OFFLOAD) &&
                                    (cntrl_nxt == ofm_pkg::TX_CTRL_INSERT);
      ctrl_fifo_wdata.begin_ofs  <= begin_nxt;
      ctrl_fifo_wdata.insert_ofs <= insert_nxt;
      ctrl_fifo_wdata.init       <= init_nxt;
      data_fifo_wdata.last       <= txd_tlast;
      data_fifo_wdata.keep       <= txd_tkeep;
      data_fifo_wdata.data       <= txd_tdata;
   end

endmodule

//--- rtl/ofm_csum_engine.sv
`timescale 1ns/1ps
// checksum engine
// pops one record and its beats, sums big-endian byte pairs from the
// begin offset in ones-complement and passes each beat to the buffer
module ofm_csum_engine
(
   input  logic                mm2s_clk,
   input  logic                mm2s_resetn,
   input  ofm_pkg::csum_ctrl_t ctrl_entry,
   input  logic                ctrl_not_empty,
   output logic                ctrl_rden,
   input  ofm_pkg::data_beat_t beat_entry,
   input  logic                beat_not_empty,
   output logic                beat_rden,
   input  logic                buf_free,
   output logic                beat_wr,
   output ofm_pkg::data_beat_t beat_out,
   output logic                done,
   output ofm_pkg::csum_t      csum,
   output ofm_pkg::csum_ctrl_t rec
);

   ofm_pkg::eng_state_t state;
   ofm_pkg::csum_t      byte_pos;
   ofm_pkg::acc_t       acc;
   ofm_pkg::acc_t       acc_nxt;
   ofm_pkg::acc_t       beat_sum;
   logic [16:0]         fold;

   // next frame only once the output buffer is drained
   assign ctrl_rden = (state == ofm_pkg::ENG_IDLE) && buf_free && ctrl_not_empty;
   assign beat_rden = (state == ofm_pkg::ENG_SUM) && beat_not_empty;

   // pair contributions of the head beat
   always_comb
   begin
      ofm_pkg::csum_t lane_pos;
      ofm_pkg::csum_t rel;
      logic [7:0]     lane_byte;
      beat_sum = '0;
      for (int i = 0; i < ofm_pkg::LANES; i++)
      begin
         lane_pos  = byte_pos + ofm_pkg::csum_t'(i);
         rel       = lane_pos - rec.begin_ofs;
         lane_byte = beat_entry.data[8*i +: 8];
         if (beat_entry.keep[i] && (lane_pos >= rec.begin_ofs))
         begin
            // even distance from begin is the high byte of its pair
            // a lone final byte thus gets a zero low byte
            if (rel[0])
               beat_sum = beat_sum + ofm_pkg::acc_t'(lane_byte);
            else
               beat_sum = beat_sum + ofm_pkg::acc_t'({lane_byte, 8'h00});
         end
      end
   end

   assign acc_nxt = acc + beat_sum;

   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         state   <= ofm_pkg::ENG_IDLE;
         beat_wr <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         beat_wr <= beat_rden;
         // high in the cycle after the second fold
         done    <= (state == ofm_pkg::ENG_DONE);
         case (state)
            ofm_pkg::ENG_IDLE:
               if (ctrl_rden)
                  state <= ofm_pkg::ENG_SUM;
            ofm_pkg::ENG_SUM:
               if (beat_rden && beat_entry.last)
                  state <= ofm_pkg::ENG_DONE;
            default:
               state <= ofm_pkg::ENG_IDLE;
         endcase
      end
   end

   // rec and csum hold until the next record is popped
   always_ff @(posedge mm2s_clk)
   begin
      beat_out <= beat_entry;
      if (ctrl_rden)
      begin
         rec      <= ctrl_entry;
         acc      <= ofm_pkg::acc_t'(ctrl_entry.init);
         byte_pos <= '0;
      end
      else if (beat_rden)
      begin
         acc      <= acc_nxt;
         byte_pos <= byte_pos + ofm_pkg::csum_t'(ofm_pkg::LANES);
         // first fold, kept from the last beat
         fold     <= 17'(acc_nxt[15:0]) + 17'(acc_nxt[ofm_pkg::ACC_W-1:16]);
      end
      // second fold cannot carry again
      if (state == ofm_pkg::ENG_DONE)
         csum <= ~(fold[15:0] + 16'(fold[16]));
   end

endmodule

//--- rtl/ofm_tx_out.sv
`timescale 1ns/1ps
// transmit output side
// holds one frame, patches the checksum at the insert offset
// and streams it out with valid/ready back-pressure
module ofm_tx_out
(
   input  logic                mm2s_clk,
   input  logic                mm2s_resetn,
   input  logic                beat_wr,
   input  ofm_pkg::data_beat_t beat_in,
   input  logic                done,
   input  ofm_pkg::csum_t      csum,
   input  ofm_pkg::csum_ctrl_t rec,
   output logic                buf_free,
   output ofm_pkg::data_word_t tx_tdata,
   output ofm_pkg::keep_t      tx_tkeep,
   output logic                tx_tlast,
   output logic                tx_tvalid,
   input  logic                tx_tready
);

   ofm_pkg::data_beat_t          mem [ofm_pkg::FRAME_WORDS];
   logic [ofm_pkg::FRAME_AW-1:0] wr_ptr;
   logic [ofm_pkg::FRAME_AW-1:0] rd_ptr;
   logic                         busy;
   logic                         tx_hs;
   logic                         load;
   ofm_pkg::data_beat_t          head;

   assign tx_hs    = tx_tvalid && tx_tready;
   // first word right after done, then one per accepted non-last word
   assign load     = done || (tx_hs && !tx_tlast);
   assign buf_free = !busy;

   always_ff @(posedge mm2s_clk)
   begin
      if (beat_wr)
         mem[wr_ptr] <= beat_in;
   end

   // checksum bytes may straddle two words, so check every lane
   always_comb
   begin
      ofm_pkg::csum_t pos;
      head = mem[rd_ptr];
      for (int i = 0; i < ofm_pkg::LANES; i++)
      begin
         pos = ofm_pkg::csum_t'({rd_ptr, 3'b000}) + ofm_pkg::csum_t'(i);
         if (rec.enable && (pos == rec.insert_ofs))
            head.data[8*i +: 8] = csum[15:8];
         if (rec.enable && (pos == rec.insert_ofs + 16'd1))
            head.data[8*i +: 8] = csum[7:0];
      end
   end

   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         busy      <= 1'b0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         tx_tvalid <= 1'b0;
      end
      else
      begin
         if (beat_wr)
         begin
            busy   <= 1'b1;
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (load)
         begin
            tx_tvalid <= 1'b1;
            rd_ptr    <= rd_ptr + 1'b1;
         end
         else if (tx_hs)
         begin
            // last word taken, buffer free again
            tx_tvalid <= 1'b0;
            busy      <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
         end
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (load)
      begin
         tx_tdata <= head.data;
         tx_tkeep <= head.keep;
         tx_tlast <= head.last;
      end
   end

   a_tx_hold: assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) &&
                                  $stable(tx_tkeep) && $stable(tx_tlast));
   // engine must wait for buf_free before refilling
   a_no_fill_while_send: assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
      beat_wr |-> !tx_tvalid);

endmodule

//--- rtl/ofm_tx_top.sv
`timescale 1ns/1ps
// transmit checksum offload top level
// input side, control and data FIFOs, checksum engine, output side
module ofm_tx_top
(
   input  logic                mm2s_clk,
   input  logic                mm2s_resetn,
   input  ofm_pkg::data_word_t txd_tdata,
   input  ofm_pkg::keep_t      txd_tkeep,
   input  logic                txd_tvalid,
   input  logic                txd_tlast,
   output logic                txd_tready,
   input  ofm_pkg::ctrl_word_t txc_tdata,
   input  logic [3:0]          txc_tkeep,
   input  logic                txc_tvalid,
   input  logic                txc_tlast,
   output logic                txc_tready,
   output ofm_pkg::data_word_t tx_tdata,
   output ofm_pkg::keep_t      tx_tkeep,
   output logic                tx_tlast,
   output logic                tx_tvalid,
   input  logic                tx_tready
);

   // control queue
   ofm_pkg::csum_ctrl_t ctrl_fifo_wdata;
   logic                ctrl_fifo_wren;
   logic                ctrl_fifo_afull;
   ofm_pkg::csum_ctrl_t ctrl_head;
   logic                ctrl_not_empty;
   logic                ctrl_rden;
   // data queue
   ofm_pkg::data_beat_t data_fifo_wdata;
   logic                data_fifo_wren;
   logic                data_fifo_afull;
   ofm_pkg::data_beat_t data_head;
   logic                data_not_empty;
   logic                data_rden;
   // engine to output buffer
   logic                beat_wr;
   ofm_pkg::data_beat_t beat_out;
   logic                done;
   ofm_pkg::csum_t      csum;
   ofm_pkg::csum_ctrl_t rec;
   logic                buf_free;

   ofm_in_fsm in_fsm_i (
      .mm2s_clk        (mm2s_clk),
      .mm2s_resetn     (mm2s_resetn),
      .txd_tdata       (txd_tdata),
      .txd_tkeep       (txd_tkeep),
      .txd_tvalid      (txd_tvalid),
      .txd_tlast       (txd_tlast),
      .txd_tready      (txd_tready),
      .txc_tdata       (txc_tdata),
      .txc_tkeep       (txc_tkeep),
      .txc_tvalid      (txc_tvalid),
      .txc_tlast       (txc_tlast),
      .txc_tready      (txc_tready),
      .ctrl_fifo_afull (ctrl_fifo_afull),
      .ctrl_fifo_wdata (ctrl_fifo_wdata),
      .ctrl_fifo_wren  (ctrl_fifo_wren),
      .data_fifo_afull (data_fifo_afull),
      .data_fifo_wdata (data_fifo_wdata),
      .data_fifo_wren  (data_fifo_wren)
   );

   ofm_sync_fifo #(.WIDTH($bits(ofm_pkg::csum_ctrl_t))) ctrl_fifo_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn),
      .wren        (ctrl_fifo_wren),
      .wdata       (ctrl_fifo_wdata),
      .rden        (ctrl_rden),
      .rdata       (ctrl_head),
      .not_empty   (ctrl_not_empty),
      .almost_full (ctrl_fifo_afull)
   );

   ofm_sync_fifo #(.WIDTH($bits(ofm_pkg::data_beat_t))) data_fifo_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn),
      .wren        (data_fifo_wren),
      .wdata       (data_fifo_wdata),
      .rden        (data_rden),
      .rdata       (data_head),
      .not_empty   (data_not_empty),
      .almost_full (data_fifo_afull)
   );

   ofm_csum_engine engine_i (
      .mm2s_clk       (mm2s_clk),
      .mm2s_resetn    (mm2s_resetn),
      .ctrl_entry     (ctrl_head),
      .ctrl_not_empty (ctrl_not_empty),
      .ctrl_rden      (ctrl_rden),
      .beat_entry     (data_head),
      .beat_not_empty (data_not_empty),
      .beat_rden      (data_rden),
      .buf_free       (buf_free),
      .beat_wr        (beat_wr),
      .beat_out       (beat_out),
      .done           (done),
      .csum           (csum),
      .rec            (rec)
   );

   ofm_tx_out tx_out_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn),
      .beat_wr     (beat_wr),
      .beat_in     (beat_out),
      .done        (done),
      .csum        (csum),
      .rec         (rec),
      .buf_free    (buf_free),
      .tx_tdata    (tx_tdata),
      .tx_tkeep    (tx_tkeep),
      .tx_tlast    (tx_tlast),
      .tx_tvalid   (tx_tvalid),
      .tx_tready   (tx_tready)
   );

endmodule

//--- tests/ofm_clk_gen.sv
`timescale 1ns/1ps
// testbench clock and reset source
// 40 ns clock, reset held low for the first 4 rising edges
module ofm_clk_gen
(
   output logic mm2s_clk,
   output logic mm2s_resetn
);

   initial
   begin
      mm2s_clk = 1'b0;
      forever #20 mm2s_clk = ~mm2s_clk;
   end

   // release lands just after the 4th edge
   initial
   begin
      mm2s_resetn = 1'b0;
      repeat (4) @(posedge mm2s_clk);
      mm2s_resetn <= 1'b1;
   end

endmodule

//--- tests/ofm_checker.sv
`timescale 1ns/1ps
// output stream checker
// compares every accepted tx beat with the expected queue,
// checks the idle levels after reset and counts errors
module ofm_checker
#(
   parameter int EXP_MAX = 4096
)
(
   input  logic                mm2s_clk,
   input  logic                mm2s_resetn,
   input  ofm_pkg::data_word_t tx_tdata,
   input  ofm_pkg::keep_t      tx_tkeep,
   input  logic                tx_tlast,
   input  logic                tx_tvalid,
   input  logic                tx_tready,
   input  logic                txc_tready,
   input  logic                txd_tready,
   input  ofm_pkg::data_beat_t exp_beats [EXP_MAX],
   input  int                  exp_test [EXP_MAX],
   input  int                  exp_count,
   output int                  rx_count,
   output int                  mismatch_count,
   output int                  other_count
);

   logic reset_checked;

   // test ids as used by the stimulus
   function automatic string test_name(input int id);
      case (id)
         0:       return "reset";
         1:       return "offload";
         2:       return "partial_last";
         3:       return "no_offload";
         4:       return "back_pressure";
         default: return "unknown";
      endcase
   endfunction

   always @(posedge mm2s_clk)
   begin
      ofm_pkg::data_beat_t act;
      int                  mis;
      int                  oth;
      mis = mismatch_count;
      oth = other_count;
      if (!mm2s_resetn)
      begin
         rx_count       <= 0;
         mismatch_count <= 0;
         other_count    <= 0;
         reset_checked  <= 1'b0;
      end
      else
      begin
         // first edge out of reset, all handshakes still idle
         if (!reset_checked)
         begin
            reset_checked <= 1'b1;
            if (tx_tvalid || txc_tready || txd_tready)
            begin
               $display("mismatch %s: expected valid/txc_ready/txd_ready 000 actual %b%b%b",
                        test_name(0), tx_tvalid, txc_tready, txd_tready);
               mis++;
            end
         end
         if (tx_tvalid && tx_tready)
         begin
            act.last = tx_tlast;
            act.keep = tx_tkeep;
            act.data = tx_tdata;
            if (rx_count >= exp_count)
            begin
               $display("output beat %0d arrived with no frame expected", rx_count);
               oth++;
            end
            else if (act !== exp_beats[rx_count])
            begin
               $display("mismatch %s beat %0d: expected %h actual %h",
                        test_name(exp_test[rx_count]), rx_count, exp_beats[rx_count], act);
               mis++;
            end
            rx_count <= rx_count + 1;
         end
         mismatch_count <= mis;
         other_count    <= oth;
      end
   end

endmodule

//--- tests/ofm_tb.sv
`timescale 1ns/1ps
// testbench for the checksum offload transmit path
// sends frames on txc/txd, queues the expected output frames
module ofm_tb;

   localparam int EXP_MAX       = 4096;
   localparam int HS_TIMEOUT    = 2000;
   localparam int DRAIN_TIMEOUT = 20000;
   localparam int T_OFFLOAD     = 1;
   localparam int T_PARTIAL     = 2;
   localparam int T_PLAIN       = 3;
   localparam int T_BACKPR      = 4;

   logic                mm2s_clk;
   logic                mm2s_resetn;
   ofm_pkg::data_word_t txd_tdata;
   ofm_pkg::keep_t      txd_tkeep;
   logic                txd_tvalid;
   logic                txd_tlast;
   logic                txd_tready;
   ofm_pkg::ctrl_word_t txc_tdata;
   logic [3:0]          txc_tkeep;
   logic                txc_tvalid;
   logic                txc_tlast;
   logic                txc_tready;
   ofm_pkg::data_word_t tx_tdata;
   ofm_pkg::keep_t      tx_tkeep;
   logic                tx_tlast;
   logic                tx_tvalid;
   logic                tx_tready = 1'b0;
   logic                rand_ready;
   // expected output beats in arrival order
   ofm_pkg::data_beat_t exp_beats [EXP_MAX];
   int                  exp_test [EXP_MAX];
   int                  exp_count;
   int                  rx_count;
   int                  mismatch_count;
   int                  other_count;
   // raised by a stalled wait
   event                timed_out;
   string               timeout_msg;

   ofm_clk_gen clk_gen_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn)
   );

   ofm_tx_top dut_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn),
      .txd_tdata   (txd_tdata),
      .txd_tkeep   (txd_tkeep),
      .txd_tvalid  (txd_tvalid),
      .txd_tlast   (txd_tlast),
      .txd_tready  (txd_tready),
      .txc_tdata   (txc_tdata),
      .txc_tkeep   (txc_tkeep),
      .txc_tvalid  (txc_tvalid),
      .txc_tlast   (txc_tlast),
      .txc_tready  (txc_tready),
      .tx_tdata    (tx_tdata),
      .tx_tkeep    (tx_tkeep),
      .tx_tlast    (tx_tlast),
      .tx_tvalid   (tx_tvalid),
      .tx_tready   (tx_tready)
   );

   ofm_checker #(.EXP_MAX(EXP_MAX)) checker_i (
      .mm2s_clk       (mm2s_clk),
      .mm2s_resetn    (mm2s_resetn),
      .tx_tdata       (tx_tdata),
      .tx_tkeep       (tx_tkeep),
      .tx_tlast       (tx_tlast),
      .tx_tvalid      (tx_tvalid),
      .tx_tready      (tx_tready),
      .txc_tready     (txc_tready),
      .txd_tready     (txd_tready),
      .exp_beats      (exp_beats),
      .exp_test       (exp_test),
      .exp_count      (exp_count),
      .rx_count       (rx_count),
      .mismatch_count (mismatch_count),
      .other_count    (other_count)
   );

   // sink always ready, random stalls in the stress phase
   always @(posedge mm2s_clk)
   begin
      if (rand_ready)
         tx_tready <= ($urandom % 4) != 0;
      else
         tx_tready <= 1'b1;
   end

   // 16-bit ones-complement sum of big-endian pairs from begin_ofs, inverted
   function automatic ofm_pkg::csum_t ref_csum(input logic [7:0] bytes [256], input int len,
                                               input int begin_ofs, input logic [15:0] init);
      logic [31:0] sum;
      logic [7:0]  lo;
      sum = 32'(init);
      for (int i = begin_ofs; i < len; i += 2)
      begin
         // odd tail gets a zero low byte
         lo  = (i + 1 < len) ? bytes[i + 1] : 8'h00;
         sum = sum + {16'h0000, bytes[i], lo};
      end
      // end-around carry
      while (sum[31:16] != 16'h0000)
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);
      return ~sum[15:0];
   endfunction

   task automatic signal_timeout(input string what);
      timeout_msg = what;
      -> timed_out;
   endtask

   // a stalled wait ends the run here
   initial
   begin
      @(timed_out);
      $display("timeout: %s", timeout_msg);
      $display("summary: %0d beats checked, %0d mismatches, %0d other errors",
               rx_count, mismatch_count, other_count + 1);
      $display("Verification failed");
      $finish;
   end

   // returns on the edge where the word is taken
   task automatic wait_accept(input logic data_side, input string what);
      int   cycles;
      logic ready;
      cycles = 0;
      @(posedge mm2s_clk);
      ready = data_side ? txd_tready : txc_tready;
      while (!ready && cycles < HS_TIMEOUT)
      begin
         @(posedge mm2s_clk);
         cycles++;
         ready = data_side ? txd_tready : txc_tready;
      end
      if (!ready)
         signal_timeout({"no ready for ", what});
   endtask

   task automatic send_frame(input int test_id, input int len, input logic [3:0] flag,
                             input logic [1:0] ctl, input int begin_ofs, input int insert_ofs,
                             input logic [15:0] init);
      logic [7:0]          bytes [256];
      logic [7:0]          patched [256];
      ofm_pkg::ctrl_word_t words [4];
      ofm_pkg::csum_t      csum;
      ofm_pkg::data_beat_t beat;
      int                  nbeats;
      // bytes past len are filler under a cleared keep
      for (int i = 0; i < 256; i++)
         bytes[i] = 8'($urandom);
      patched = bytes;
      nbeats  = (len + 7) / 8;
      csum    = ref_csum(bytes, len, begin_ofs, init);
      if (flag == 4'b1000 && ctl == 2'b01)
      begin
         patched[insert_ofs]     = csum[15:8];
         patched[insert_ofs + 1] = csum[7:0];
      end
      for (int b = 0; b < nbeats; b++)
      begin
         for (int l = 0; l < 8; l++)
         begin
            beat.data[8*l +: 8] = patched[8*b + l];
            beat.keep[l]        = (8*b + l < len);
         end
         beat.last                = (b == nbeats - 1);
         exp_beats[exp_count] = beat;
         exp_test[exp_count]  = test_id;
         exp_count++;
      end
      // unused control bits carry noise
      words[0] = {flag, 28'($urandom)};
      words[1] = {30'($urandom), ctl};
      words[2] = {16'(begin_ofs), 16'(insert_ofs)};
      words[3] = {16'($urandom), init};
      for (int w = 0; w < 4; w++)
      begin
         txc_tdata  <= words[w];
         txc_tkeep  <= 4'hf;
         txc_tlast  <= (w == 3);
         txc_tvalid <= 1'b1;
         wait_accept(1'b0, "control word");
      end
      txc_tvalid <= 1'b0;
      txc_tlast  <= 1'b0;
      for (int b = 0; b < nbeats; b++)
      begin
         for (int l = 0; l < 8; l++)
         begin
            beat.data[8*l +: 8] = bytes[8*b + l];
            beat.keep[l]        = (8*b + l < len);
         end
         txd_tdata  <= beat.data;
         txd_tkeep  <= beat.keep;
         txd_tlast  <= (b == nbeats - 1);
         txd_tvalid <= 1'b1;
         wait_accept(1'b1, "data beat");
      end
      txd_tvalid <= 1'b0;
      txd_tlast  <= 1'b0;
   endtask

   initial
   begin
      int         len;
      int         beg;
      int         ins;
      int         cycles;
      logic [3:0] flag;
      logic [1:0] ctl;
      txd_tdata  = '0;
      txd_tkeep  = '0;
      txd_tvalid = 1'b0;
      txd_tlast  = 1'b0;
      txc_tdata  = '0;
      txc_tkeep  = '0;
      txc_tvalid = 1'b0;
      txc_tlast  = 1'b0;
      rand_ready = 1'b0;
      exp_count  = 0;
      void'($urandom(32'hba7c));
      cycles     = 0;
      while (!mm2s_resetn && cycles < HS_TIMEOUT)
      begin
         @(posedge mm2s_clk);
         cycles++;
      end
      if (!mm2s_resetn)
         signal_timeout("reset never released");
      // even and odd begin, insert bytes split over two words
      send_frame(T_OFFLOAD, 64, 4'b1000, 2'b01, 14, 24, 16'h0000);
      send_frame(T_OFFLOAD, 60, 4'b1000, 2'b01, 15, 40, 16'h1234);
      send_frame(T_OFFLOAD, 40, 4'b1000, 2'b01, 3, 7, 16'habcd);
      // odd length, short keep on the last beat
      send_frame(T_PARTIAL, 45, 4'b1000, 2'b01, 14, 30, 16'h0f0f);
      send_frame(T_PARTIAL, 13, 4'b1000, 2'b01, 0, 2, 16'hffff);
      // frames that pass unchanged
      send_frame(T_PLAIN, 48, 4'b1000, 2'b10, 14, 20, 16'h0000);
      send_frame(T_PLAIN, 33, 4'b0100, 2'b01, 2, 10, 16'h5a5a);
      send_frame(T_PLAIN, 24, 4'b1001, 2'b01, 0, 4, 16'h0001);
      // back to back with a stalling sink
      rand_ready <= 1'b1;
      for (int f = 0; f < 24; f++)
      begin
         len  = 9 + int'($urandom % 248);
         beg  = int'($urandom % len);
         ins  = int'($urandom % (len - 1));
         flag = (($urandom % 4) != 0) ? 4'b1000 : 4'($urandom);
         ctl  = (($urandom % 4) != 0) ? 2'b01 : 2'($urandom);
         send_frame(T_BACKPR, len, flag, ctl, beg, ins, 16'($urandom));
      end
      cycles = 0;
      while (rx_count < exp_count && cycles < DRAIN_TIMEOUT)
      begin
         @(posedge mm2s_clk);
         cycles++;
      end
      // catch stray beats after the last frame
      repeat (10) @(posedge mm2s_clk);
      if (rx_count < exp_count)
         signal_timeout($sformatf("missing frame data, %0d of %0d beats arrived",
                                  rx_count, exp_count));
      else
      begin
         $display("summary: %0d beats checked, %0d mismatches, %0d other errors",
                  rx_count, mismatch_count, other_count);
         if (mismatch_count == 0 && other_count == 0)
            $display("Verification passed");
         else
            $display("Verification failed");
         $finish;
      end
   end

endmodule

//--- ofm_tx.f
rtl/ofm_pkg.sv
rtl/ofm_sync_fifo.sv
rtl/ofm_in_fsm.sv
rtl/ofm_csum_engine.sv
rtl/ofm_tx_out.sv
rtl/ofm_tx_top.sv
tests/ofm_clk_gen.sv
tests/ofm_checker.sv
tests/ofm_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the checksum offload testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ofm_tx.f --top-module ofm_tb \
   -Mdir obj_dir -o ofm_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ofm_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Verification passed$" sim.log; then
   exit 0
fi
exit 1
